/* src/rtg_params.svh */
/* Register map, ID and timing constants for the RTG display path.
   RTG_MEM_LATENCY must be at least 1 and match the external memory. */
`ifndef RTG_PARAMS_SVH
`define RTG_PARAMS_SVH

// ----------------------------------------
// Host register block
// ----------------------------------------
// Block select, compared against rs[10:8]
`define RTG_REG_HI_ADDR  3'd1
// Word offsets within the block, rs[3:1]
`define RTG_REG_BASE_HI  3'd0
`define RTG_REG_BASE_LO  3'd1
`define RTG_REG_FORMAT   3'd2
`define RTG_REG_ENABLE   3'd3
`define RTG_REG_HSIZE    3'd4
`define RTG_REG_VSIZE    3'd5
`define RTG_REG_STRIDE   3'd6
`define RTG_REG_ID       3'd7
// ID 0x50, version 0x01
`define RTG_ID_VALUE     16'h5001

// ----------------------------------------
// Memory and palette
// ----------------------------------------
// Cycles from mem_rd to valid mem_data
`define RTG_MEM_LATENCY  2
`define RTG_CLUT_ENTRIES 256

`endif

/* src/rtg_pkg.sv */
/* Shared types of the RTG display path.
   Format codes other than the three listed here display black. */
`default_nettype none

package rtg_pkg;

	// ----------------------------------------
	// Pixel formats
	// ----------------------------------------
	typedef enum logic [4:0] {
		FMT_CLUT8  = 5'd0,
		FMT_RGB565 = 5'd1,
		FMT_XRGB32 = 5'd2
	} fmt_t;

	// Display settings, held as levels by the register block
	typedef struct packed {
		logic [31:0] base;
		fmt_t        format;
		logic        ena;
		logic [11:0] hsize;
		logic [11:0] vsize;
		// Bytes from one line start to the next
		logic [13:0] stride;
	} disp_cfg_t;

	// Full-entry palette write
	typedef struct packed {
		logic        we;
		logic [7:0]  addr;
		logic [23:0] data;
	} clut_wr_t;

	// Request tag, travels alongside each memory read
	typedef struct packed {
		// Low address bits, pixel position inside the word
		logic [1:0] byte_lane;
		logic       sof;
		logic       eol;
		logic       valid;
	} pix_tag_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

endpackage

`default_nettype wire

/* src/clut_ram.sv */
/* Palette memory, contents undefined until written.
   Host read is combinational, video read has one cycle of latency. */
`timescale 1ns/1ps
`default_nettype none

`include "rtg_params.svh"

module clut_ram (
	input  wire                   clk,
	// Host side
	input  wire rtg_pkg::clut_wr_t wr,
	input  wire [7:0]             host_addr,
	output rtg_pkg::rgb_t         host_data,
	// Video side
	input  wire [7:0]             vid_addr,
	output rtg_pkg::rgb_t         vid_data
);
	import rtg_pkg::*;

	rgb_t mem [`RTG_CLUT_ENTRIES];

	// Single write port, owned by the host
	always_ff @(posedge clk) begin
		if (wr.we)
			mem[wr.addr] <= rgb_t'(wr.data);
	end

	// Host readback, registered later in the bus logic
	assign host_data = mem[host_addr];

	// Video lookup
	always_ff @(posedge clk) begin
		vid_data <= mem[vid_addr];
	end

endmodule

`default_nettype wire

/* src/rtg_regs.sv */
/* Host side register file and palette access, writes qualified by clk7_en.
   Reads need no clk7_en; data_out is zero unless a read is in progress. */
`timescale 1ns/1ps
`default_nettype none

`include "rtg_params.svh"

module rtg_regs (
	input  wire                   clk,
	input  wire                   reset,
	// Host register bus
	input  wire                   clk7_en,
	input  wire                   aen,
	input  wire                   rd,
	input  wire                   wr,
	input  wire [11:0]            rs,
	input  wire [15:0]            data_in,
	output logic [15:0]           data_out,
	// Display settings
	output rtg_pkg::disp_cfg_t    cfg,
	// Palette ports
	output rtg_pkg::clut_wr_t     clut_wr,
	output logic [7:0]            clut_raddr,
	input  wire rtg_pkg::rgb_t    clut_rdata
);
	import rtg_pkg::*;

	logic        reg_sel;
	logic        pal_sel;
	logic        wr_cyc;
	logic        rd_cyc;
	// Last written palette halves
	logic [7:0]  pal_hi;
	logic [15:0] pal_lo;

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	// rs[10] set means palette space, so the two selects never overlap
	assign reg_sel = (rs[10:8] == `RTG_REG_HI_ADDR);
	assign pal_sel = rs[10];
	assign wr_cyc  = clk7_en && aen && wr;
	assign rd_cyc  = aen && rd;

	// Display register writes
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg.ena <= 1'b0;
		end else if (wr_cyc && reg_sel) begin
			case (rs[3:1])
				`RTG_REG_BASE_HI: cfg.base[31:16] <= data_in;
				`RTG_REG_BASE_LO: cfg.base[15:0]  <= data_in;
				`RTG_REG_FORMAT:  cfg.format      <= fmt_t'(data_in[4:0]);
				`RTG_REG_ENABLE:  cfg.ena         <= data_in[0];
				`RTG_REG_HSIZE:   cfg.hsize       <= data_in[11:0];
				`RTG_REG_VSIZE:   cfg.vsize       <= data_in[11:0];
				`RTG_REG_STRIDE:  cfg.stride      <= data_in[13:0];
				// ID is read only
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// Palette
	// ----------------------------------------
	// Each half write is remembered for the next write of the other half
	always_ff @(posedge clk) begin
		if (wr_cyc && pal_sel) begin
			if (rs[1])
				pal_lo <= data_in;
			else
				pal_hi <= data_in[7:0];
		end
	end

	// Whole entry written at once, new half merged with the latched one
	always_comb begin
		clut_wr.we   = wr_cyc && pal_sel;
		clut_wr.addr = rs[9:2];
		if (rs[1])
			clut_wr.data = {pal_hi, data_in};
		else
			clut_wr.data = {data_in[7:0], pal_lo};
	end

	assign clut_raddr = rs[9:2];

	// ----------------------------------------
	// Readback
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			data_out <= '0;
		end else if (rd_cyc && pal_sel) begin
			// Half 0 is red, half 1 is green and blue
			if (rs[1])
				data_out <= clut_rdata[15:0];
			else
				data_out <= {8'h00, clut_rdata[23:16]};
		end else if (rd_cyc && reg_sel) begin
			case (rs[3:1])
				`RTG_REG_BASE_HI: data_out <= cfg.base[31:16];
				`RTG_REG_BASE_LO: data_out <= cfg.base[15:0];
				`RTG_REG_FORMAT:  data_out <= {11'd0, cfg.format};
				`RTG_REG_ENABLE:  data_out <= {15'd0, cfg.ena};
				`RTG_REG_HSIZE:   data_out <= {4'd0, cfg.hsize};
				`RTG_REG_VSIZE:   data_out <= {4'd0, cfg.vsize};
				`RTG_REG_STRIDE:  data_out <= {2'd0, cfg.stride};
				default:          data_out <= `RTG_ID_VALUE;
			endcase
		end else begin
			data_out <= '0;
		end
	end

endmodule

`default_nettype wire

/* src/fb_scan.sv */
/* Framebuffer scanner, one read per clk while enabled, frames back to back.
   Memory must accept every strobe and answer after exactly RTG_MEM_LATENCY cycles. */
`timescale 1ns/1ps
`default_nettype none

`include "rtg_params.svh"

module fb_scan (
	input  wire                     clk,
	input  wire                     reset,
	input  wire rtg_pkg::disp_cfg_t cfg,
	// External memory
	output logic                    mem_rd,
	output logic [31:0]             mem_addr,
	// Tag aligned with returned data
	output rtg_pkg::pix_tag_t       tag
);
	import rtg_pkg::*;

	logic [11:0] x;
	logic [11:0] y;
	// Offset of the current line from base
	logic [31:0] line_off;
	logic [1:0]  bpp_shift;
	logic [31:0] byte_addr;
	logic        active;
	logic        last_x;
	logic        last_y;
	pix_tag_t    req_tag;
	pix_tag_t    tag_pipe [`RTG_MEM_LATENCY];

	// ----------------------------------------
	// Address generation
	// ----------------------------------------
	assign active = cfg.ena && (cfg.hsize != 12'd0) && (cfg.vsize != 12'd0);
	// Compare with >= so that shrinking the size mid frame still wraps
	assign last_x = (x >= cfg.hsize - 12'd1);
	assign last_y = (y >= cfg.vsize - 12'd1);

	// Bytes per pixel as a shift
	always_comb begin
		case (cfg.format)
			FMT_CLUT8:  bpp_shift = 2'd0;
			FMT_RGB565: bpp_shift = 2'd1;
			default:    bpp_shift = 2'd2;
		endcase
	end

	assign byte_addr = cfg.base + line_off + (32'(x) << bpp_shift);

	// ----------------------------------------
	// Pixel and line counters
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset || !active) begin
			// Disabled, next frame starts again at pixel 0
			x        <= '0;
			y        <= '0;
			line_off <= '0;
			req_tag  <= '0;
		end else begin
			req_tag.valid     <= 1'b1;
			req_tag.byte_lane <= byte_addr[1:0];
			req_tag.sof       <= (x == 12'd0) && (y == 12'd0);
			req_tag.eol       <= last_x;
			mem_addr          <= {byte_addr[31:2], 2'b00};
			if (last_x) begin
				x <= '0;
				if (last_y) begin
					y        <= '0;
					line_off <= '0;
				end else begin
					y        <= y + 12'd1;
					line_off <= line_off + 32'(cfg.stride);
				end
			end else begin
				x <= x + 12'd1;
			end
		end
	end

	// Strobe and address leave on the same edge as the tag
	assign mem_rd = req_tag.valid;

	// Tag delay line, one stage per cycle of memory latency
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RTG_MEM_LATENCY; i++)
				tag_pipe[i] <= '0;
		end else begin
			tag_pipe[0] <= req_tag;
			for (int i = 1; i < `RTG_MEM_LATENCY; i++)
				tag_pipe[i] <= tag_pipe[i-1];
		end
	end

	assign tag = tag_pipe[`RTG_MEM_LATENCY-1];

endmodule

`default_nettype wire

/* src/pixel_unpack.sv */
/* Pixel unpacker, two cycles from returned word to pixel for every format.
   Lane 0 is mem_data[7:0]; unknown formats show black. */
`timescale 1ns/1ps
`default_nettype none

module pixel_unpack (
	input  wire                    clk,
	input  wire                    reset,
	input  wire rtg_pkg::fmt_t     format,
	input  wire rtg_pkg::pix_tag_t tag,
	input  wire [31:0]             mem_data,
	// Palette lookup
	output logic [7:0]             clut_addr,
	input  wire rtg_pkg::rgb_t     clut_data,
	// Pixel out
	output logic                   pix_valid,
	output rtg_pkg::rgb_t          pix_rgb,
	output logic                   pix_sof,
	output logic                   pix_eol
);
	import rtg_pkg::*;

	logic [7:0]  lane_byte;
	logic [15:0] lane_half;
	rgb_t        direct_rgb;
	// Stage 1, in step with the palette read
	pix_tag_t    s1_tag;
	rgb_t        s1_rgb;
	logic        s1_use_clut;

	// ----------------------------------------
	// Lane select and expansion
	// ----------------------------------------
	assign lane_byte = mem_data[8*tag.byte_lane +: 8];
	assign lane_half = tag.byte_lane[1] ? mem_data[31:16] : mem_data[15:0];

	// Index goes straight to the palette, result back next cycle
	assign clut_addr = lane_byte;

	always_comb begin
		case (format)
			FMT_RGB565: begin
				// Top bits repeated into the low bits of each channel
				direct_rgb.r = {lane_half[15:11], lane_half[15:13]};
				direct_rgb.g = {lane_half[10:5], lane_half[10:9]};
				direct_rgb.b = {lane_half[4:0], lane_half[4:2]};
			end
			FMT_XRGB32: direct_rgb = rgb_t'(mem_data[23:0]);
			default:    direct_rgb = '0;
		endcase
	end

	// ----------------------------------------
	// Alignment stage
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			s1_tag <= '0;
		else
			s1_tag <= tag;
	end

	always_ff @(posedge clk) begin
		s1_rgb      <= direct_rgb;
		s1_use_clut <= (format == FMT_CLUT8);
	end

	// Output register
	always_ff @(posedge clk) begin
		if (reset) begin
			pix_valid <= 1'b0;
			pix_sof   <= 1'b0;
			pix_eol   <= 1'b0;
		end else begin
			pix_valid <= s1_tag.valid;
			pix_sof   <= s1_tag.valid && s1_tag.sof;
			pix_eol   <= s1_tag.valid && s1_tag.eol;
		end
		pix_rgb <= s1_use_clut ? clut_data : s1_rgb;
	end

endmodule

`default_nettype wire

/* src/rtg_top.sv */
/* RTG display path top, single clock, no back-pressure on memory or pixels.
   A pixel leaves RTG_MEM_LATENCY + 2 cycles after its mem_rd. */
`timescale 1ns/1ps
`default_nettype none

module rtg_top (
	input  wire                clk,
	input  wire                reset,
	// Host register bus
	input  wire                clk7_en,
	input  wire                aen,
	input  wire                rd,
	input  wire                wr,
	input  wire [11:0]         rs,
	input  wire [15:0]         data_in,
	output logic [15:0]        data_out,
	// Framebuffer memory
	output logic               mem_rd,
	output logic [31:0]        mem_addr,
	input  wire [31:0]         mem_data,
	// Pixel stream
	output logic               pix_valid,
	output rtg_pkg::rgb_t      pix_rgb,
	output logic               pix_sof,
	output logic               pix_eol
);
	import rtg_pkg::*;

	disp_cfg_t  cfg;
	clut_wr_t   clut_wr;
	logic [7:0] host_addr;
	rgb_t       host_data;
	logic [7:0] vid_addr;
	rgb_t       vid_data;
	pix_tag_t   tag;

	// ----------------------------------------
	// Host side
	// ----------------------------------------
	rtg_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.clk7_en    (clk7_en),
		.aen        (aen),
		.rd         (rd),
		.wr         (wr),
		.rs         (rs),
		.data_in    (data_in),
		.data_out   (data_out),
		.cfg        (cfg),
		.clut_wr    (clut_wr),
		.clut_raddr (host_addr),
		.clut_rdata (host_data)
	);

	clut_ram u_clut (
		.clk       (clk),
		.wr        (clut_wr),
		.host_addr (host_addr),
		.host_data (host_data),
		.vid_addr  (vid_addr),
		.vid_data  (vid_data)
	);

	// ----------------------------------------
	// Video side
	// ----------------------------------------
	fb_scan u_scan (
		.clk      (clk),
		.reset    (reset),
		.cfg      (cfg),
		.mem_rd   (mem_rd),
		.mem_addr (mem_addr),
		.tag      (tag)
	);

	// Format comes live from the registers, sampled with each word
	pixel_unpack u_unpack (
		.clk       (clk),
		.reset     (reset),
		.format    (cfg.format),
		.tag       (tag),
		.mem_data  (mem_data),
		.clut_addr (vid_addr),
		.clut_data (vid_data),
		.pix_valid (pix_valid),
		.pix_rgb   (pix_rgb),
		.pix_sof   (pix_sof),
		.pix_eol   (pix_eol)
	);

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
/* Clock and reset source for the testbench, reset is synchronous and active high.
   Reset drops after RESET_CYCLES rising edges. */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);
	// Free running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset held over the first edges
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* bench/rtg_tb.sv */
/* Testbench for rtg_top with a fixed latency memory model and a reference scanner.
   Checks stop at the first mismatch; CLUT and sizes are random from a fixed seed. */
`timescale 1ns/1ps
`default_nettype none

`include "rtg_params.svh"

module rtg_tb;
	import rtg_pkg::*;

	localparam int PIPE = `RTG_MEM_LATENCY + 2;
	localparam int MAX_H = 12;
	localparam int MAX_V = 5;
	// Cycles for the palette fill, the random half writes and the full readback
	localparam int CLUT_CYCLES = 2 * 256 * 2 + 64 * 2 + 2 * 256 * 3;
	localparam int SETUP_CYCLES = CLUT_CYCLES + 200;
	// Two frames per format and a partial plus two frames on restart
	localparam int FRAMES = 3 * 2 + 3;
	localparam int WATCHDOG_CYCLES = 2 * (SETUP_CYCLES + FRAMES * (MAX_H * MAX_V + 60));

	// Expected pixel as it travels from request to output
	typedef struct packed {
		logic        valid;
		logic        sof;
		logic        eol;
		logic [31:0] addr;
		rgb_t        rgb;
	} exp_pix_t;

	logic        clk;
	logic        reset;
	logic        clk7_en = 1'b0;
	logic        aen = 1'b0;
	logic        rd = 1'b0;
	logic        wr = 1'b0;
	logic [11:0] rs = '0;
	logic [15:0] data_in = '0;
	logic [15:0] data_out;
	logic        mem_rd;
	logic [31:0] mem_addr;
	logic [31:0] mem_data;
	logic        pix_valid;
	rgb_t        pix_rgb;
	logic        pix_sof;
	logic        pix_eol;

	integer      seed = 43800;
	int          pix_count;
	int          req_count;
	// Model of the display registers and the palette
	disp_cfg_t   shadow = '0;
	logic        sh_active;
	rgb_t        clut_copy [`RTG_CLUT_ENTRIES];
	logic [7:0]  lat_hi = '0;
	logic [15:0] lat_lo = '0;
	logic [11:0] rx;
	logic [11:0] ry;
	exp_pix_t    exp_req;
	exp_pix_t    exp_pipe [PIPE];
	exp_pix_t    exp_out;
	logic [31:0] data_q [`RTG_MEM_LATENCY];

	tb_clock #(.PERIOD(20), .RESET_CYCLES(3)) u_clock (.clk(clk), .reset(reset));

	rtg_top DUT (
		.clk(clk), .reset(reset), .clk7_en(clk7_en), .aen(aen), .rd(rd), .wr(wr),
		.rs(rs), .data_in(data_in), .data_out(data_out),
		.mem_rd(mem_rd), .mem_addr(mem_addr), .mem_data(mem_data),
		.pix_valid(pix_valid), .pix_rgb(pix_rgb), .pix_sof(pix_sof), .pix_eol(pix_eol)
	);

	// ----------------------------------------
	// Reporting
	// ----------------------------------------
	task automatic end_with_failure(input string why);
		$display(">>> FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end_with_failure("Stopped at the first mismatch");
	endtask

	// ----------------------------------------
	// Memory model and reference scanner
	// ----------------------------------------
	// Each byte mixes word address bits with a lane constant
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] w;
		w = '0;
		for (int k = 0; k < 4; k++)
			w[8*k +: 8] = addr[9:2] ^ addr[17:10] ^ (8'h5a + 8'(k * 59));
		return w;
	endfunction

	function automatic int bytes_per_pixel(input logic [4:0] fmt);
		if (fmt == FMT_CLUT8)
			return 1;
		else if (fmt == FMT_RGB565)
			return 2;
		return 4;
	endfunction

	function automatic rgb_t expected_pixel(input logic [31:0] addr, input logic [4:0] fmt);
		logic [31:0] w;
		logic [15:0] half;
		logic [7:0]  r5;
		logic [7:0]  g6;
		logic [7:0]  b5;
		rgb_t        p;
		w = mem_word({addr[31:2], 2'b00});
		half = addr[1] ? w[31:16] : w[15:0];
		r5 = 8'(half[15:11]);
		g6 = 8'(half[10:5]);
		b5 = 8'(half[4:0]);
		case (fmt)
			FMT_CLUT8: p = clut_copy[8'(w >> (8 * addr[1:0]))];
			FMT_RGB565: begin
				// Scale each field to 8 bits by its own top bits
				p.r = (r5 << 3) | (r5 >> 2);
				p.g = (g6 << 2) | (g6 >> 4);
				p.b = (b5 << 3) | (b5 >> 2);
			end
			FMT_XRGB32: p = rgb_t'(w[23:0]);
			default:    p = '0;
		endcase
		return p;
	endfunction

	always @(posedge clk) begin
		data_q[0] <= mem_rd ? mem_word(mem_addr) : 32'h0;
		for (int i = 1; i < `RTG_MEM_LATENCY; i++)
			data_q[i] <= data_q[i-1];
	end
	assign mem_data = reset ? 32'h0 : data_q[`RTG_MEM_LATENCY-1];

	assign sh_active = shadow.ena && (shadow.hsize != 12'd0) && (shadow.vsize != 12'd0);

	// Request expected at each edge while enabled and restarting at pixel 0 otherwise
	always @(posedge clk) begin
		if (reset || !sh_active) begin
			rx      <= '0;
			ry      <= '0;
			exp_req <= '0;
		end else begin
			exp_req.valid <= 1'b1;
			exp_req.sof   <= (rx == 12'd0) && (ry == 12'd0);
			exp_req.eol   <= (rx == shadow.hsize - 12'd1);
			exp_req.addr  <= shadow.base + 32'(ry) * 32'(shadow.stride)
				+ 32'(rx) * bytes_per_pixel(shadow.format);
			exp_req.rgb   <= expected_pixel(shadow.base + 32'(ry) * 32'(shadow.stride)
				+ 32'(rx) * bytes_per_pixel(shadow.format), shadow.format);
			if (rx == shadow.hsize - 12'd1) begin
				rx <= '0;
				ry <= (ry == shadow.vsize - 12'd1) ? 12'd0 : ry + 12'd1;
			end else begin
				rx <= rx + 12'd1;
			end
		end
	end

	// Expected pixels delayed to the output stage
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < PIPE; i++)
				exp_pipe[i] <= '0;
		end else begin
			exp_pipe[0] <= exp_req;
			for (int i = 1; i < PIPE; i++)
				exp_pipe[i] <= exp_pipe[i-1];
		end
	end
	assign exp_out = exp_pipe[PIPE-1];

	always @(posedge clk) begin
		if (reset) begin
			pix_count <= 0;
			req_count <= 0;
		end else begin
			if (pix_valid)
				pix_count <= pix_count + 1;
			if (mem_rd)
				req_count <= req_count + 1;
		end
	end

	// ----------------------------------------
	// Assertions
	// ----------------------------------------
	a_req: assert property (@(posedge clk) disable iff (reset) mem_rd == exp_req.valid)
		else report_mismatch("mem_rd", 32'(mem_rd), 32'(exp_req.valid));
	a_addr: assert property (@(posedge clk) disable iff (reset)
		mem_rd |-> mem_addr == {exp_req.addr[31:2], 2'b00})
		else report_mismatch("mem_addr", mem_addr, {exp_req.addr[31:2], 2'b00});
	// Valid must follow mem_rd by exactly RTG_MEM_LATENCY + 2 cycles
	a_valid: assert property (@(posedge clk) disable iff (reset) pix_valid == exp_out.valid)
		else report_mismatch("pix_valid", 32'(pix_valid), 32'(exp_out.valid));
	a_rgb: assert property (@(posedge clk) disable iff (reset) pix_valid |-> pix_rgb == exp_out.rgb)
		else report_mismatch("pix_rgb", {8'h00, pix_rgb}, {8'h00, exp_out.rgb});
	a_sof: assert property (@(posedge clk) disable iff (reset) pix_valid |-> pix_sof == exp_out.sof)
		else report_mismatch("pix_sof", 32'(pix_sof), 32'(exp_out.sof));
	a_eol: assert property (@(posedge clk) disable iff (reset) pix_valid |-> pix_eol == exp_out.eol)
		else report_mismatch("pix_eol", 32'(pix_eol), 32'(exp_out.eol));

	// ----------------------------------------
	// Host bus tasks
	// ----------------------------------------
	function automatic logic [11:0] reg_rs(input logic [2:0] off);
		return {1'b0, `RTG_REG_HI_ADDR, 4'b0000, off, 1'b0};
	endfunction

	function automatic logic [11:0] clut_rs(input logic [7:0] idx, input logic half);
		return {1'b0, 1'b1, idx, half, 1'b0};
	endfunction

	task automatic bus_write(input logic [11:0] addr, input logic [15:0] d);
		@(posedge clk);
		clk7_en <= 1'b1;
		aen     <= 1'b1;
		wr      <= 1'b1;
		rs      <= addr;
		data_in <= d;
		@(posedge clk);
		clk7_en <= 1'b0;
		aen     <= 1'b0;
		wr      <= 1'b0;
	endtask

	// data_out sampled at the falling edge before it clears again
	task automatic check_read(input string name, input logic [11:0] addr, input logic [15:0] exp);
		logic [15:0] got;
		@(posedge clk);
		clk7_en <= 1'b1;
		aen     <= 1'b1;
		rd      <= 1'b1;
		rs      <= addr;
		@(posedge clk);
		clk7_en <= 1'b0;
		aen     <= 1'b0;
		rd      <= 1'b0;
		@(negedge clk);
		got = data_out;
		assert (got == exp) else report_mismatch(name, 32'(got), 32'(exp));
	endtask

	// Shadow changes on the same edge as the register
	task automatic set_register(input logic [2:0] off, input logic [15:0] val);
		bus_write(reg_rs(off), val);
		case (off)
			`RTG_REG_BASE_HI: shadow.base[31:16] <= val;
			`RTG_REG_BASE_LO: shadow.base[15:0]  <= val;
			`RTG_REG_FORMAT:  shadow.format      <= fmt_t'(val[4:0]);
			`RTG_REG_ENABLE:  shadow.ena         <= val[0];
			`RTG_REG_HSIZE:   shadow.hsize       <= val[11:0];
			`RTG_REG_VSIZE:   shadow.vsize       <= val[11:0];
			`RTG_REG_STRIDE:  shadow.stride      <= val[13:0];
			default: ;
		endcase
	endtask

	// New half merged with the last written other half
	task automatic set_clut_half(input logic [7:0] idx, input logic half, input logic [15:0] val);
		bus_write(clut_rs(idx, half), val);
		if (half) begin
			clut_copy[idx] = {lat_hi, val};
			lat_lo = val;
		end else begin
			clut_copy[idx] = {val[7:0], lat_lo};
			lat_hi = val[7:0];
		end
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic register_test();
		logic [15:0] vals [7];
		logic [15:0] mask;
		for (int i = 0; i < 7; i++) begin
			// Enable bit kept clear so the scanner stays idle
			vals[i] = (i == `RTG_REG_ENABLE) ? 16'hfffe : 16'($random(seed));
			set_register(3'(i), vals[i]);
		end
		for (int i = 0; i < 7; i++) begin
			case (i)
				`RTG_REG_FORMAT: mask = 16'h001f;
				`RTG_REG_ENABLE: mask = 16'h0001;
				`RTG_REG_HSIZE, `RTG_REG_VSIZE: mask = 16'h0fff;
				`RTG_REG_STRIDE: mask = 16'h3fff;
				default: mask = 16'hffff;
			endcase
			check_read($sformatf("data_out reg %0d", i), reg_rs(3'(i)), vals[i] & mask);
		end
		check_read("data_out id", reg_rs(`RTG_REG_ID), `RTG_ID_VALUE);
	endtask

	task automatic clut_test();
		logic [7:0] idx;
		logic       half;
		for (int i = 0; i < 256; i++) begin
			set_clut_half(8'(i), 1'b0, 16'($random(seed)));
			set_clut_half(8'(i), 1'b1, 16'($random(seed)));
		end
		// Lone half writes pick up the other half from a different entry
		repeat (64) begin
			idx  = 8'($random(seed));
			half = 1'($random(seed));
			set_clut_half(idx, half, 16'($random(seed)));
		end
		for (int i = 0; i < 256; i++) begin
			check_read("data_out clut hi", clut_rs(8'(i), 1'b0), {8'h00, clut_copy[i].r});
			check_read("data_out clut lo", clut_rs(8'(i), 1'b1), {clut_copy[i].g, clut_copy[i].b});
		end
	endtask

	task automatic configure(input logic [4:0] fmt, input logic [11:0] h, input logic [11:0] v,
		input logic [13:0] stride, input logic [31:0] base);
		set_register(`RTG_REG_BASE_HI, base[31:16]);
		set_register(`RTG_REG_BASE_LO, base[15:0]);
		set_register(`RTG_REG_FORMAT, {11'd0, fmt});
		set_register(`RTG_REG_HSIZE, {4'd0, h});
		set_register(`RTG_REG_VSIZE, {4'd0, v});
		set_register(`RTG_REG_STRIDE, {2'd0, stride});
	endtask

	task automatic wait_pixels(input int n);
		int target;
		target = pix_count + n;
		while (pix_count < target)
			@(negedge clk);
	endtask

	// In-flight pixels need RTG_MEM_LATENCY + 2 cycles
	task automatic drain_check();
		repeat (PIPE + 1) @(posedge clk);
		@(negedge clk);
		assert (pix_count == req_count) else report_mismatch("pixel count", pix_count, req_count);
	endtask

	task automatic video_test(input logic [4:0] fmt);
		int          bpp;
		logic [11:0] h;
		logic [11:0] v;
		logic [13:0] stride;
		logic [31:0] base;
		bpp = bytes_per_pixel(fmt);
		h = 12'(3 + $unsigned($random(seed)) % (MAX_H - 2));
		v = 12'(2 + $unsigned($random(seed)) % (MAX_V - 1));
		// Gap after each line so stride differs from the line length
		stride = 14'(h * bpp + 4 + $unsigned($random(seed)) % 16);
		base = 32'($random(seed)) & ~32'(bpp - 1);
		configure(fmt, h, v, stride, base);
		set_register(`RTG_REG_ENABLE, 16'h0001);
		check_read("data_out enable", reg_rs(`RTG_REG_ENABLE), 16'h0001);
		wait_pixels(2 * h * v);
		set_register(`RTG_REG_ENABLE, 16'h0000);
		drain_check();
	endtask

	task automatic restart_test();
		configure(FMT_CLUT8, 12'(MAX_H), 12'd4, 14'(MAX_H + 8), 32'($random(seed)));
		set_register(`RTG_REG_ENABLE, 16'h0001);
		// Stop inside the first line
		wait_pixels(3);
		set_register(`RTG_REG_ENABLE, 16'h0000);
		drain_check();
		set_register(`RTG_REG_ENABLE, 16'h0001);
		wait_pixels(2 * MAX_H * 4);
		set_register(`RTG_REG_ENABLE, 16'h0000);
		drain_check();
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		end_with_failure("Timeout, the tests did not finish within the cycle limit");
	end

	initial begin
		@(negedge clk);
		while (reset)
			@(negedge clk);
		repeat (4) @(negedge clk);
		check_read("data_out enable", reg_rs(`RTG_REG_ENABLE), 16'h0000);
		register_test();
		clut_test();
		video_test(FMT_CLUT8);
		video_test(FMT_RGB565);
		video_test(FMT_XRGB32);
		restart_test();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/rtg_pkg.sv
src/clut_ram.sv
src/rtg_regs.sv
src/fb_scan.sv
src/pixel_unpack.sv
src/rtg_top.sv
bench/tb_clock.sv
bench/rtg_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the RTG testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rtg_tb \
	-Mdir obj_dir -o rtg_sim -f src.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/rtg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi
exit 0
